// File: hw/sd_reg_bank_pkg.sv
/*
  SD register bank shared definitions
  entry widths and indices, ring-bus word layout, bank write and read
  slot structs, burst FSM states
*/
package sd_reg_bank_pkg;

  // widths of the source buses
  localparam int REG_ENTRIES  = 16;
  localparam int CMD_W        = 126;
  localparam int DAT_PTR_W    = 3;
  localparam int HOST_STATE_W = 16;

  typedef logic [63:0] reg_word_t;
  typedef logic [3:0]  reg_idx_t;
  typedef logic [38:0] host_adr_t;
  typedef logic [71:0] ring_word_t;

  // --------------------------------------------------
  // entry map
  // --------------------------------------------------
  // 0x00..0x07 sd status, 0x0e never written
  localparam reg_idx_t IDX_CID_HI = 4'h8;
  localparam reg_idx_t IDX_CSD_HI = 4'hA;
  localparam reg_idx_t IDX_STATUS = 4'hC;
  localparam reg_idx_t IDX_OCR    = 4'hD;
  localparam reg_idx_t IDX_HOST   = 4'hF;

  // --------------------------------------------------
  // ring-bus packet format
  // --------------------------------------------------
  localparam int         PKT_DATA_WORDS = 8;
  localparam int         PKT_PER_READ   = 2;
  localparam int         PKT_ADR_STEP   = 64;
  localparam logic [3:0] HDR_TAG        = 4'h8;
  localparam logic [2:0] HDR_TYPE       = 3'b010;
  localparam logic [7:0] DATA_TAG       = 8'hFF;
  // bank read reg plus packet reg
  localparam int         PIPE_SLACK     = 2;

  typedef struct packed {
    logic       sof;
    ring_word_t word;
  } ring_beat_t;

  typedef struct packed {
    logic      en;
    reg_idx_t  idx;
    reg_word_t dat;
  } reg_wr_t;

  typedef struct packed {
    logic     valid;
    logic     sof;
    reg_idx_t idx;
  } rd_slot_t;

  typedef enum logic [2:0] {
    IDLE,
    ROOM_WAIT,
    HEADER,
    DATA,
    STOP
  } burst_state_t;

endpackage

// File: hw/reg_write_capture.sv
/*
  register write capture
  merges command, data and host-state strobes into one bank write port,
  CID/CSD land as two writes on consecutive cycles
*/
module reg_write_capture #(
  parameter logic [sd_reg_bank_pkg::HOST_STATE_W-1:0] HW_VER = 16'd1
) (
  input  logic                                      CLK,
  input  logic                                      RST,
  input  logic                                      i_cmd_en,
  input  logic [sd_reg_bank_pkg::CMD_W-1:0]         i_cmd,
  input  logic                                      i_cmd_sta,
  input  logic                                      i_cmd_ocr,
  input  logic                                      i_cmd_cid,
  input  logic                                      i_cmd_csd,
  input  logic                                      i_dat_en,
  input  sd_reg_bank_pkg::reg_word_t                i_dat,
  input  logic [sd_reg_bank_pkg::DAT_PTR_W-1:0]     i_dat_ptr,
  input  logic                                      i_host_state_en,
  input  logic [sd_reg_bank_pkg::HOST_STATE_W-1:0]  i_host_state,
  output sd_reg_bank_pkg::reg_wr_t                  o_wr
);
  import sd_reg_bank_pkg::*;

  // pending upper half of CID/CSD
  logic      hi_pend;
  reg_idx_t  hi_idx;
  reg_word_t hi_dat;
  logic      cmd_pair;
  // next write, then its register
  reg_wr_t   wr_nxt;
  logic      wr_en_q;
  reg_idx_t  wr_idx_q;
  reg_word_t wr_dat_q;

  assign cmd_pair = i_cmd_en & (i_cmd_cid | i_cmd_csd);

  // --------------------------------------------------
  // upper half latched on the strobe itself
  // --------------------------------------------------
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      hi_pend <= 1'b0;
    end else begin
      // one-cycle window, lost on collision
      hi_pend <= cmd_pair;
    end
  end

  always_ff @(posedge CLK) begin
    if (cmd_pair) begin
      hi_idx <= i_cmd_cid ? IDX_CID_HI : IDX_CSD_HI;
      // valid flag, seven zeros, card bits 119:64
      hi_dat <= {1'b1, 7'd0, i_cmd[119:64]};
    end
  end

  // --------------------------------------------------
  // priority: data, command, upper half, host state
  // --------------------------------------------------
  always_comb begin
    wr_nxt = '0;
    if (i_dat_en) begin
      wr_nxt.en  = 1'b1;
      // status block stored word-reversed
      wr_nxt.idx = {1'b0, ~i_dat_ptr};
      wr_nxt.dat = i_dat;
    end else if (i_cmd_en) begin
      wr_nxt.en = i_cmd_cid | i_cmd_csd | i_cmd_sta | i_cmd_ocr;
      if (i_cmd_cid) begin
        wr_nxt.idx = IDX_CID_HI + reg_idx_t'(1);
        wr_nxt.dat = i_cmd[63:0];
      end else if (i_cmd_csd) begin
        wr_nxt.idx = IDX_CSD_HI + reg_idx_t'(1);
        wr_nxt.dat = i_cmd[63:0];
      end else if (i_cmd_sta) begin
        wr_nxt.idx = IDX_STATUS;
        wr_nxt.dat = {32'd0, i_cmd[31:0]};
      end else begin
        wr_nxt.idx = IDX_OCR;
        wr_nxt.dat = {32'd0, i_cmd[31:0]};
      end
    end else if (hi_pend) begin
      wr_nxt.en  = 1'b1;
      wr_nxt.idx = hi_idx;
      wr_nxt.dat = hi_dat;
    end else if (i_host_state_en) begin
      wr_nxt.en  = 1'b1;
      wr_nxt.idx = IDX_HOST;
      wr_nxt.dat = {32'd0, HW_VER, i_host_state};
    end
  end

  // registered write port
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_en_q <= 1'b0;
    end else begin
      wr_en_q <= wr_nxt.en;
    end
  end

  always_ff @(posedge CLK) begin
    wr_idx_q <= wr_nxt.idx;
    wr_dat_q <= wr_nxt.dat;
  end

  assign o_wr = '{en: wr_en_q, idx: wr_idx_q, dat: wr_dat_q};

endmodule

// File: hw/reg_file.sv
/*
  register bank storage
  sixteen 64-bit entries, one write port, one registered read port
*/
module reg_file (
  input  logic                       CLK,
  input  logic                       RST,
  input  sd_reg_bank_pkg::reg_wr_t   i_wr,
  input  sd_reg_bank_pkg::rd_slot_t  i_slot,
  output sd_reg_bank_pkg::reg_word_t o_rd_dat,
  output logic                       o_rd_en,
  output logic                       o_rd_sof
);
  import sd_reg_bank_pkg::*;

  reg_word_t bank [REG_ENTRIES];

  // unwritten entries read back as all-ones
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < REG_ENTRIES; i++) begin
        bank[i] <= '1;
      end
    end else if (i_wr.en) begin
      bank[i_wr.idx] <= i_wr.dat;
    end
  end

  // read data one cycle after the slot
  always_ff @(posedge CLK) begin
    o_rd_dat <= bank[i_slot.idx];
  end

  // slot flags follow the data
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      o_rd_en  <= 1'b0;
      o_rd_sof <= 1'b0;
    end else begin
      o_rd_en  <= i_slot.valid;
      o_rd_sof <= i_slot.valid & i_slot.sof;
    end
  end

endmodule

// File: hw/read_burst_ctrl.sv
/*
  read burst control FSM
  paces the packets of one read, waits for FIFO room before each header,
  issues bank read slots and pulses the request acknowledge
*/
module read_burst_ctrl (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      i_req_rd,
  input  logic                      i_room,
  output sd_reg_bank_pkg::rd_slot_t o_slot,
  output logic                      o_load_base,
  output logic                      o_advance_base,
  output logic                      o_req_ack
);
  import sd_reg_bank_pkg::*;

  localparam int WORD_W = $clog2(PKT_DATA_WORDS);
  localparam int PKT_W  = $clog2(PKT_PER_READ);

  burst_state_t     state_q;
  burst_state_t     state_d;
  // runs over all sixteen entries of one read
  reg_idx_t         entry_cnt;
  logic [PKT_W-1:0] pkt_cnt;
  logic             last_word;
  logic             last_pkt;

  assign last_word = entry_cnt[WORD_W-1:0] == WORD_W'(PKT_DATA_WORDS - 1);
  assign last_pkt  = pkt_cnt == PKT_W'(PKT_PER_READ - 1);

  // --------------------------------------------------
  // next state
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (i_req_rd) begin
          state_d = ROOM_WAIT;
        end
      end
      ROOM_WAIT: begin
        // whole packet fits, never split
        if (i_room) begin
          state_d = HEADER;
        end
      end
      HEADER: begin
        state_d = DATA;
      end
      DATA: begin
        if (last_word) begin
          state_d = STOP;
        end
      end
      STOP: begin
        state_d = last_pkt ? IDLE : ROOM_WAIT;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // --------------------------------------------------
  // state, counters, acknowledge
  // --------------------------------------------------
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q   <= IDLE;
      entry_cnt <= '0;
      pkt_cnt   <= '0;
      o_req_ack <= 1'b0;
    end else begin
      state_q   <= state_d;
      // one cycle after the last STOP
      o_req_ack <= (state_q == STOP) & last_pkt;
      case (state_q)
        IDLE: begin
          entry_cnt <= '0;
          pkt_cnt   <= '0;
        end
        DATA: begin
          entry_cnt <= entry_cnt + reg_idx_t'(1);
        end
        STOP: begin
          pkt_cnt <= pkt_cnt + PKT_W'(1);
        end
        default: begin
          entry_cnt <= entry_cnt;
        end
      endcase
    end
  end

  // header slot carries sof, its bank data is dropped later
  always_comb begin
    o_slot.valid = (state_q == HEADER) | (state_q == DATA);
    o_slot.sof   = state_q == HEADER;
    o_slot.idx   = entry_cnt;
  end

  // base sampled while idle, stepped once per packet
  assign o_load_base    = state_q == IDLE;
  assign o_advance_base = state_q == STOP;

endmodule

// File: hw/packet_former.sv
/*
  ring-bus packet former
  keeps the packet base address and registers header or data ring words
*/
module packet_former (
  input  logic                        CLK,
  input  logic                        RST,
  input  sd_reg_bank_pkg::host_adr_t  i_req_adr,
  input  logic                        i_load_base,
  input  logic                        i_advance_base,
  input  sd_reg_bank_pkg::reg_word_t  i_rd_dat,
  input  logic                        i_rd_en,
  input  logic                        i_rd_sof,
  output sd_reg_bank_pkg::ring_beat_t o_beat,
  output logic                        o_beat_en
);
  import sd_reg_bank_pkg::*;

  host_adr_t  base_adr;
  ring_word_t hdr_word;
  ring_word_t dat_word;
  ring_word_t word_q;
  logic       sof_q;

  // --------------------------------------------------
  // packet base address
  // --------------------------------------------------
  always_ff @(posedge CLK) begin
    if (i_load_base) begin
      base_adr <= i_req_adr;
    end else if (i_advance_base) begin
      base_adr <= base_adr + host_adr_t'(PKT_ADR_STEP);
    end
  end

  // tag, 28 zeros, one, 8-byte aligned address, type
  assign hdr_word = {HDR_TAG, 28'd0, 1'b1, base_adr[38:3], HDR_TYPE};
  assign dat_word = {DATA_TAG, i_rd_dat};

  // --------------------------------------------------
  // output register
  // --------------------------------------------------
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      o_beat_en <= 1'b0;
    end else begin
      o_beat_en <= i_rd_en;
    end
  end

  always_ff @(posedge CLK) begin
    sof_q  <= i_rd_sof;
    word_q <= i_rd_sof ? hdr_word : dat_word;
  end

  assign o_beat = '{sof: sof_q, word: word_q};

endmodule

// File: hw/out_fifo.sv
/*
  output FIFO for ring beats
  circular buffer with occupancy count, room flag for one whole packet
  plus words in flight, popped on stb and ack together
*/
module out_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                        CLK,
  input  logic                        RST,
  input  sd_reg_bank_pkg::ring_beat_t i_beat,
  input  logic                        i_beat_en,
  input  logic                        i_ack,
  output sd_reg_bank_pkg::ring_beat_t o_beat,
  output logic                        o_stb,
  output logic                        o_room
);
  import sd_reg_bank_pkg::*;

  localparam int PTR_W    = $clog2(FIFO_DEPTH);
  localparam int CNT_W    = $clog2(FIFO_DEPTH + 1);
  // header, data words and pipeline slack must still fit
  localparam int ROOM_MAX = FIFO_DEPTH - (PKT_DATA_WORDS + 1 + PIPE_SLACK);

  ring_beat_t       mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  assign push = i_beat_en;
  assign pop  = o_stb & i_ack;

  // --------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  // storage
  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= i_beat;
    end
  end

  // head of queue shown while non-empty
  assign o_beat = mem[rd_ptr];
  assign o_stb  = count != '0;
  assign o_room = count <= CNT_W'(ROOM_MAX);

endmodule

// File: hw/sd_reg_bank.sv
/*
  SD host register bank
  captures responses, data words and host state into sixteen entries
  and streams the bank out as two ring-bus packets per read request
*/
module sd_reg_bank #(
  parameter logic [sd_reg_bank_pkg::HOST_STATE_W-1:0] HW_VER = 16'd1,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                                      CLK,
  input  logic                                      RST,
  // read request
  input  logic                                      i_req_rd,
  input  sd_reg_bank_pkg::host_adr_t                i_req_adr,
  output logic                                      o_req_ack,
  // command responses
  input  logic                                      i_cmd_en,
  input  logic [sd_reg_bank_pkg::CMD_W-1:0]         i_cmd,
  input  logic                                      i_cmd_sta,
  input  logic                                      i_cmd_ocr,
  input  logic                                      i_cmd_cid,
  input  logic                                      i_cmd_csd,
  // status block words
  input  logic                                      i_dat_en,
  input  sd_reg_bank_pkg::reg_word_t                i_dat,
  input  logic [sd_reg_bank_pkg::DAT_PTR_W-1:0]     i_dat_ptr,
  // host state
  input  logic                                      i_host_state_en,
  input  logic [sd_reg_bank_pkg::HOST_STATE_W-1:0]  i_host_state,
  // ring-bus output
  output sd_reg_bank_pkg::ring_word_t               o_dat,
  output logic                                      o_stb,
  output logic                                      o_sof,
  input  logic                                      i_ack
);
  import sd_reg_bank_pkg::*;

  // write path
  reg_wr_t    bank_wr;
  // read pipeline
  rd_slot_t   rd_slot;
  reg_word_t  rd_dat;
  logic       rd_en;
  logic       rd_sof;
  logic       load_base;
  logic       advance_base;
  ring_beat_t beat;
  logic       beat_en;
  // fifo side
  logic       room;
  ring_beat_t fifo_beat;

  reg_write_capture #(
    .HW_VER(HW_VER)
  ) u_capture (
    .CLK(CLK), .RST(RST),
    .i_cmd_en(i_cmd_en), .i_cmd(i_cmd),
    .i_cmd_sta(i_cmd_sta), .i_cmd_ocr(i_cmd_ocr),
    .i_cmd_cid(i_cmd_cid), .i_cmd_csd(i_cmd_csd),
    .i_dat_en(i_dat_en), .i_dat(i_dat), .i_dat_ptr(i_dat_ptr),
    .i_host_state_en(i_host_state_en), .i_host_state(i_host_state),
    .o_wr(bank_wr)
  );

  reg_file u_bank (
    .CLK(CLK), .RST(RST),
    .i_wr(bank_wr), .i_slot(rd_slot),
    .o_rd_dat(rd_dat), .o_rd_en(rd_en), .o_rd_sof(rd_sof)
  );

  read_burst_ctrl u_ctrl (
    .CLK(CLK), .RST(RST),
    .i_req_rd(i_req_rd), .i_room(room),
    .o_slot(rd_slot), .o_load_base(load_base),
    .o_advance_base(advance_base), .o_req_ack(o_req_ack)
  );

  packet_former u_former (
    .CLK(CLK), .RST(RST),
    .i_req_adr(i_req_adr), .i_load_base(load_base), .i_advance_base(advance_base),
    .i_rd_dat(rd_dat), .i_rd_en(rd_en), .i_rd_sof(rd_sof),
    .o_beat(beat), .o_beat_en(beat_en)
  );

  out_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .CLK(CLK), .RST(RST),
    .i_beat(beat), .i_beat_en(beat_en), .i_ack(i_ack),
    .o_beat(fifo_beat), .o_stb(o_stb), .o_room(room)
  );

  // split the popped beat onto the ring pins
  assign o_dat = fifo_beat.word;
  assign o_sof = fifo_beat.sof;

endmodule

// File: testbench/tb_model.svh
/*
  reference model of the SD register bank
  applies the write rules to its own sixteen entries and builds the
  expected ring-bus words of one read
*/
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// model entries, all-ones out of reset
reg_word_t  bank_model [16];
// expected ring words in pop order
ring_beat_t exp_q [$];

function automatic void reset_bank_model();
  for (int i = 0; i < 16; i++) begin
    bank_model[i] = '1;
  end
endfunction

// status block words land at the inverted pointer
function automatic void store_data_word(input logic [2:0] ptr, input reg_word_t dat);
  bank_model[7 - ptr] = dat;
endfunction

// kind 1 cid, 2 csd, 3 status, 4 ocr
function automatic void store_cmd_response(input int kind, input logic [125:0] cmd);
  case (kind)
    1: begin
      // low half in the odd entry, flagged upper half in the even one
      bank_model[9] = cmd[63:0];
      bank_model[8] = {1'b1, 7'd0, cmd[119:64]};
    end
    2: begin
      bank_model[11] = cmd[63:0];
      bank_model[10] = {1'b1, 7'd0, cmd[119:64]};
    end
    3: begin
      // zero-extended 32-bit card status
      bank_model[12] = {32'd0, cmd[31:0]};
    end
    default: begin
      bank_model[13] = {32'd0, cmd[31:0]};
    end
  endcase
endfunction

// version in the upper half of the low word
function automatic void store_host_state(input logic [15:0] state);
  bank_model[15] = {32'd0, HW_VER, state};
endfunction

// header then eight data words per packet
function automatic void queue_read_packets(input host_adr_t adr);
  host_adr_t  base;
  ring_beat_t beat;
  for (int p = 0; p < 2; p++) begin
    // base steps by 64 bytes per packet
    base = adr + host_adr_t'(64 * p);
    beat.sof  = 1'b1;
    beat.word = {4'h8, 28'd0, 1'b1, base[38:3], 3'b010};
    exp_q.push_back(beat);
    for (int w = 0; w < 8; w++) begin
      beat.sof  = 1'b0;
      beat.word = {8'hFF, bank_model[8 * p + w]};
      exp_q.push_back(beat);
    end
  end
endfunction

`endif

// File: testbench/sd_reg_bank_tb.sv
/*
  SD register bank testbench
  random writes and reads from a fixed seed, ring words checked in order
  against the bank model, acknowledge timing and count checked
*/
module sd_reg_bank_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import sd_reg_bank_pkg::*;

  localparam int          CLK_PERIOD = 10;
  localparam logic [15:0] HW_VER     = 16'h0a51;
  localparam int          NUM_ROUNDS = 12;
  localparam int          MAX_WRITES = 8;
  // rounds plus the read after reset and the busy read
  localparam int          NUM_REQ    = NUM_ROUNDS + 2;
  localparam int          ACK_LIMIT  = 1000;
  localparam int          WATCHDOG_CYCLES = NUM_REQ * 200 + NUM_ROUNDS * MAX_WRITES * 6 + 20;

  logic         CLK;
  logic         RST;
  logic         req_rd;
  host_adr_t    req_adr;
  logic         req_ack;
  logic         cmd_en;
  logic [125:0] cmd;
  logic         cmd_sta;
  logic         cmd_ocr;
  logic         cmd_cid;
  logic         cmd_csd;
  logic         dat_en;
  reg_word_t    dat;
  logic [2:0]   dat_ptr;
  logic         host_state_en;
  logic [15:0]  host_state;
  ring_word_t   o_dat;
  logic         o_stb;
  logic         o_sof;
  logic         ack;
  // generator states, counters
  logic [31:0]  rng;
  logic [31:0]  ack_rng;
  logic         ack_random;
  int           value_errs;
  int           other_errs;
  int           words_seen;
  int           ack_cnt;
  ring_beat_t   exp_beat;

  `include "tb_model.svh"

  sd_reg_bank #(
    .HW_VER(HW_VER),
    .FIFO_DEPTH(16)
  ) i_dut (
    .CLK(CLK), .RST(RST),
    .i_req_rd(req_rd), .i_req_adr(req_adr), .o_req_ack(req_ack),
    .i_cmd_en(cmd_en), .i_cmd(cmd), .i_cmd_sta(cmd_sta), .i_cmd_ocr(cmd_ocr),
    .i_cmd_cid(cmd_cid), .i_cmd_csd(cmd_csd),
    .i_dat_en(dat_en), .i_dat(dat), .i_dat_ptr(dat_ptr),
    .i_host_state_en(host_state_en), .i_host_state(host_state),
    .o_dat(o_dat), .o_stb(o_stb), .o_sof(o_sof), .i_ack(ack)
  );

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // ring-bus pop acknowledge, full or random duty
  always @(negedge CLK) begin
    if (ack_random) begin
      ack_rng = xorshift32(ack_rng);
      ack = ack_rng[7];
    end else begin
      ack = 1'b1;
    end
  end

  // --------------------------------------------------
  // output monitor, sampled on the pop edge
  // --------------------------------------------------
  always @(posedge CLK) begin
    if (!RST) begin
      if (req_ack) begin
        ack_cnt++;
      end
      if (o_stb && ack) begin
        assert (exp_q.size() != 0) else begin
          other_errs++;
          $display("ring word popped while no word was expected");
        end
        if (exp_q.size() != 0) begin
          exp_beat = exp_q.pop_front();
          words_seen++;
          assert (o_dat == exp_beat.word) else begin
            value_errs++;
            $display("error: o_dat expected %h got %h", exp_beat.word, o_dat);
          end
          assert (o_sof == exp_beat.sof) else begin
            value_errs++;
            $display("error: o_sof expected %h got %h", exp_beat.sof, o_sof);
          end
        end
      end
    end
  end

  // one strobe of a random kind, bus scrambled after it, then a gap
  task automatic random_write();
    int          kind;
    logic [31:0] r;
    logic [15:0] state;
    kind = int'(next_rand() % 6);
    cmd[31:0]  = next_rand();
    cmd[63:32] = next_rand();
    cmd[95:64] = next_rand();
    r = next_rand();
    cmd[125:96] = r[29:0];
    dat[31:0]  = next_rand();
    dat[63:32] = next_rand();
    r = next_rand();
    dat_ptr = r[2:0];
    state   = r[31:16];
    case (kind)
      0: begin
        dat_en = 1'b1;
        store_data_word(dat_ptr, dat);
      end
      5: begin
        host_state_en = 1'b1;
        host_state    = state;
        store_host_state(state);
      end
      default: begin
        cmd_en  = 1'b1;
        cmd_cid = kind == 1;
        cmd_csd = kind == 2;
        cmd_sta = kind == 3;
        cmd_ocr = kind == 4;
        store_cmd_response(kind, cmd);
      end
    endcase
    @(negedge CLK);
    {dat_en, cmd_en, host_state_en} = 3'b000;
    {cmd_cid, cmd_csd, cmd_sta, cmd_ocr} = 4'b0000;
    // upper CID/CSD bits must already be latched
    cmd = ~cmd;
    dat = ~dat;
    repeat (2 + int'(next_rand() % 4)) @(negedge CLK);
  endtask

  // request one read, optional latency check with busy requests
  task automatic issue_read(input host_adr_t adr, input logic timed);
    int cycles;
    queue_read_packets(adr);
    req_adr = adr;
    req_rd  = 1'b1;
    cycles  = 0;
    do begin
      @(negedge CLK);
      cycles++;
      // extra requests while busy must be ignored
      req_rd = timed && (cycles == 5 || cycles == 15);
    end while (!req_ack && cycles < ACK_LIMIT);
    assert (req_ack) else begin
      other_errs++;
      $display("no request acknowledge within %0d cycles", ACK_LIMIT);
    end
    if (timed) begin
      assert (cycles == 23) else begin
        value_errs++;
        $display("error: o_req_ack delay expected %h got %h", 23, cycles);
      end
    end
    @(negedge CLK);
    assert (!req_ack) else begin
      other_errs++;
      $display("request acknowledge stayed high for more than one cycle");
    end
  endtask

  task automatic wait_fifo_empty();
    int n;
    n = 0;
    while (o_stb && n < ACK_LIMIT) begin
      @(negedge CLK);
      n++;
    end
    assert (!o_stb) else begin
      other_errs++;
      $display("output FIFO did not drain");
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    host_adr_t   adr;
    logic [31:0] r;
    {CLK, RST, req_rd, req_adr} = {1'b0, 1'b1, 1'b0, 39'd0};
    {cmd_en, cmd, cmd_sta, cmd_ocr, cmd_cid, cmd_csd} = '0;
    {dat_en, dat, dat_ptr, host_state_en, host_state} = '0;
    {ack, ack_random} = 2'b10;
    {value_errs, other_errs, words_seen, ack_cnt} = {32'd0, 32'd0, 32'd0, 32'd0};
    rng     = 32'h5afe;
    ack_rng = xorshift32(xorshift32(32'h5afe));
    reset_bank_model();
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);
    assert (!o_stb && !req_ack) else begin
      other_errs++;
      $display("strobe or acknowledge high after reset");
    end
    // all-ones bank straight after reset
    adr = {next_rand(), 7'h15};
    issue_read(adr, 1'b1);
    for (int rnd = 0; rnd < NUM_ROUNDS; rnd++) begin
      repeat (1 + int'(next_rand() % MAX_WRITES)) random_write();
      ack_random = rnd[0];
      r = next_rand();
      adr = {r[6:0], next_rand()};
      issue_read(adr, 1'b0);
    end
    // latency needs an empty FIFO and a full-rate pop
    ack_random = 1'b0;
    wait_fifo_empty();
    adr = {next_rand(), 7'h6c};
    issue_read(adr, 1'b1);
    wait_fifo_empty();
    // late extra packets would show up here
    repeat (40) @(negedge CLK);
    assert (exp_q.size() == 0) else begin
      other_errs++;
      $display("%0d expected ring words never appeared", exp_q.size());
    end
    assert (ack_cnt == NUM_REQ) else begin
      value_errs++;
      $display("error: o_req_ack pulses expected %h got %h", NUM_REQ, ack_cnt);
    end
    $display("words checked %0d, value errors %0d, other errors %0d",
             words_seen, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // watchdog sized from the request count and write phase
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("simulation timed out after %0d cycles", WATCHDOG_CYCLES);
    $display("words checked %0d, value errors %0d, other errors %0d",
             words_seen, value_errs, other_errs);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: all.f
+incdir+testbench
hw/sd_reg_bank_pkg.sv
hw/reg_write_capture.sv
hw/reg_file.sv
hw/read_burst_ctrl.sv
hw/packet_former.sv
hw/out_fifo.sv
hw/sd_reg_bank.sv
testbench/sd_reg_bank_tb.sv
